/* hw/pd_consts.svh */
// Decoder widths and field positions
`ifndef PD_CONSTS_SVH
`define PD_CONSTS_SVH

// Word sizes
`define PD_W     16 // IR and W bus width
`define PD_R0_W  9  // R0 flag count
`define PD_OP_W  6  // Primary opcode width
`define PD_FLD_W 3  // A, B and C register fields
`define PD_SA_W  6  // Short argument magnitude, B and C together

// Field bounds, bit 0 is the MSB
`define PD_OP_HI 0
`define PD_OP_LO 5
`define PD_D_BIT 6  // D bit, sign or modifier
`define PD_A_HI  7
`define PD_A_LO  9
`define PD_B_HI  10
`define PD_B_LO  12
`define PD_C_HI  13
`define PD_C_LO  15

`endif

/* hw/pd_isa_pkg.sv */
// Instruction set classes and R0 flags
package pd_isa_pkg;

	// Primary opcode class, one per octal opcode range
	typedef enum logic [2:0] {
		OC_ILLEGAL = 3'd0, // 000-017, 076-077
		OC_NORM    = 3'd1, // 020-057, normal argument
		OC_KA1     = 3'd2, // 060-067, short argument group
		OC_JUMP    = 3'd3, // 070, conditional jumps
		OC_KA2     = 3'd4, // 071
		OC_SHIFT   = 3'd5, // 072
		OC_SYS     = 3'd6, // 073, system group
		OC_INOU    = 3'd7  // 074-075, IN and OU
	} op_class_t;

	// R0 flag positions, bit 0 is the MSB of R0
	localparam int R0_Z = 0; // Zero
	localparam int R0_M = 1; // Minus
	localparam int R0_V = 2; // Overflow
	localparam int R0_C = 3; // Carry
	localparam int R0_L = 4; // Less
	localparam int R0_E = 5; // Equal
	localparam int R0_G = 6; // Greater
	localparam int R0_Y = 7; // Shift extension Y
	localparam int R0_X = 8; // Shift extension X

endpackage

/* hw/pd_ctl_pkg.sv */
// Execution control types
package pd_ctl_pkg;

	// ALU function picked by the decoder
	typedef enum logic [2:0] {
		ALU_NONE = 3'd0, // No ALU use
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_OR   = 3'd4,
		ALU_XOR  = 3'd5,
		ALU_PASS = 3'd6  // Operand through unchanged
	} alu_fn_t;

endpackage

/* hw/pd_ir_dec.sv */
// Instruction register and opcode decoder
`timescale 1ns/1ps
`include "pd_consts.svh"

module pd_ir_dec (
	input  logic                    strob1,   // Main timing strobe
	input  logic                    rst_n,
	input  logic [0:`PD_W-1]        w,        // W bus
	input  logic                    w_ir,     // W->IR load strobe
	input  logic                    si1,      // Kill opcode MSBs
	output logic [0:`PD_W-1]        ir,       // Instruction register
	output logic                    ir_valid, // IR holds a loaded word
	output pd_isa_pkg::op_class_t   op_class,
	output logic [0:`PD_FLD_W-1]    a_field,
	output logic [0:`PD_FLD_W-1]    b_field,
	output logic                    d_bit,
	output logic                    c0,       // C field nonzero
	output logic                    b0        // B field nonzero
);

	logic [0:`PD_OP_W-1]  opcode;  // Primary opcode bits 0..5
	logic [0:`PD_FLD_W-1] c_field;

	// IR load and invalidate
	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n) begin
			ir       <= '0;
			ir_valid <= 1'b0;
		end else if (w_ir) begin
			ir       <= w;    // Load beats si1
			ir_valid <= 1'b1;
		end else if (si1) begin
			// Top two opcode bits cleared, word falls into 000-017
			ir[`PD_OP_HI:`PD_OP_HI+1] <= 2'b00;
		end
	end

	// Field split
	assign opcode  = ir[`PD_OP_HI:`PD_OP_LO];
	assign d_bit   = ir[`PD_D_BIT];
	assign a_field = ir[`PD_A_HI:`PD_A_LO];
	assign b_field = ir[`PD_B_HI:`PD_B_LO];
	assign c_field = ir[`PD_C_HI:`PD_C_LO];

	// Zero tests on B and C, quiet until a word is loaded
	assign c0 = ir_valid & (|c_field);
	assign b0 = ir_valid & (|b_field);

	// Opcode range decoder
	always_comb begin
		case (opcode) inside
			[6'o20:6'o57]: op_class = pd_isa_pkg::OC_NORM;  // Two-arg normal
			[6'o60:6'o67]: op_class = pd_isa_pkg::OC_KA1;   // Short argument
			6'o70:         op_class = pd_isa_pkg::OC_JUMP;
			6'o71:         op_class = pd_isa_pkg::OC_KA2;
			6'o72:         op_class = pd_isa_pkg::OC_SHIFT;
			6'o73:         op_class = pd_isa_pkg::OC_SYS;   // HLT, MCL, LIP and kin
			[6'o74:6'o75]: op_class = pd_isa_pkg::OC_INOU;
			default:       op_class = pd_isa_pkg::OC_ILLEGAL; // 000-017, 076-077
		endcase
	end

endmodule

/* hw/pd_legality.sv */
// Illegal and ineffective instruction check
`timescale 1ns/1ps
`include "pd_consts.svh"

module pd_legality #(
	parameter bit INOU_USER_ILLEGAL = 1'b1 // IN/OU trap in user mode
) (
	input  logic                  ir_valid,
	input  pd_isa_pkg::op_class_t op_class,
	input  logic [0:`PD_FLD_W-1]  a_field,  // Jump condition, system subop
	input  logic [0:`PD_FLD_W-1]  b_field,  // Shift subop
	input  logic                  q,        // System flag, user mode
	input  logic [0:`PD_R0_W-1]   r0,       // R0 flags
	input  logic                  skip,     // Skip request from previous op
	output logic                  xi,       // Illegal instruction
	output logic                  nef       // Ineffective instruction
);

	logic bad_class;  // Undefined opcode range
	logic bad_sys;    // Privileged or undefined system op
	logic bad_shift;  // Undefined shift group member
	logic bad_inou;   // User IN/OU
	logic cond_flag;  // R0 flag picked by the jump condition
	logic jump_nef;   // Jump condition not met

	assign bad_class = (op_class == pd_isa_pkg::OC_ILLEGAL);

	// System ops trap in user mode, subops 5..7 never exist
	assign bad_sys = (op_class == pd_isa_pkg::OC_SYS) &
		(q | (a_field >= 3'd5));

	assign bad_shift = (op_class == pd_isa_pkg::OC_SHIFT) & (b_field > 3'd1);

	assign bad_inou = (op_class == pd_isa_pkg::OC_INOU) & q & INOU_USER_ILLEGAL;

	assign xi = ir_valid & (bad_class | bad_sys | bad_shift | bad_inou);

	// Condition select, A field names the flag
	always_comb begin
		case (a_field)
			3'd1:    cond_flag = r0[pd_isa_pkg::R0_Z];
			3'd2:    cond_flag = r0[pd_isa_pkg::R0_M];
			3'd3:    cond_flag = r0[pd_isa_pkg::R0_V];
			3'd4:    cond_flag = r0[pd_isa_pkg::R0_C];
			3'd5:    cond_flag = r0[pd_isa_pkg::R0_L];
			3'd6:    cond_flag = r0[pd_isa_pkg::R0_E];
			3'd7:    cond_flag = r0[pd_isa_pkg::R0_G];
			default: cond_flag = 1'b1; // A=0, plain jump always taken
		endcase
	end

	assign jump_nef = (op_class == pd_isa_pkg::OC_JUMP) & ~cond_flag;

	// Illegal wins over ineffective
	assign nef = ir_valid & ~xi & (skip | jump_nef);

endmodule

/* hw/pd_alu_ctl.sv */
// ALU function select and short argument
`timescale 1ns/1ps
`include "pd_consts.svh"

module pd_alu_ctl (
	input  logic                  ir_valid,
	input  pd_isa_pkg::op_class_t op_class,
	input  logic [0:`PD_W-1]      ir,
	input  logic                  d_bit,     // KA1 sign
	output pd_ctl_pkg::alu_fn_t   alu_fn,
	output logic                  aryt,      // Arithmetic mode
	output logic [0:`PD_W-1]      short_arg  // Signed short argument
);

	logic [0:2]          fn_sel;  // Opcode low bits for the normal group
	logic [0:`PD_W-1]    sa_ext;  // B and C fields, zero-extended
	logic                is_ka1;

	assign fn_sel = ir[`PD_OP_LO-2:`PD_OP_LO];
	assign is_ka1 = ir_valid & (op_class == pd_isa_pkg::OC_KA1);

	// Function select
	always_comb begin
		alu_fn = pd_ctl_pkg::ALU_NONE;
		if (ir_valid) begin
			case (op_class)
				pd_isa_pkg::OC_NORM: begin
					case (fn_sel)
						3'd0:    alu_fn = pd_ctl_pkg::ALU_ADD;
						3'd1:    alu_fn = pd_ctl_pkg::ALU_SUB;
						3'd2:    alu_fn = pd_ctl_pkg::ALU_AND;
						3'd3:    alu_fn = pd_ctl_pkg::ALU_OR;
						3'd4:    alu_fn = pd_ctl_pkg::ALU_XOR;
						default: alu_fn = pd_ctl_pkg::ALU_PASS; // Loads, stores
					endcase
				end
				pd_isa_pkg::OC_KA1: begin
					// D set means negative argument
					alu_fn = d_bit ? pd_ctl_pkg::ALU_SUB : pd_ctl_pkg::ALU_ADD;
				end
				pd_isa_pkg::OC_JUMP: alu_fn = pd_ctl_pkg::ALU_PASS; // Target to IC
				default: alu_fn = pd_ctl_pkg::ALU_NONE;
			endcase
		end
	end

	assign aryt = (alu_fn == pd_ctl_pkg::ALU_ADD) | (alu_fn == pd_ctl_pkg::ALU_SUB);

	// Short argument, bits 10..15
	assign sa_ext = {{(`PD_W-`PD_SA_W){1'b0}}, ir[`PD_B_HI:`PD_C_LO]};

	always_comb begin
		if (!is_ka1)
			short_arg = '0;            // Only KA1 carries one
		else if (d_bit)
			short_arg = -sa_ext;       // Two's complement
		else
			short_arg = sa_ext;
	end

endmodule

/* hw/pd_top.sv */
// Instruction decode stage top
`timescale 1ns/1ps
`include "pd_consts.svh"

module pd_top #(
	parameter bit INOU_USER_ILLEGAL = 1'b1
) (
	input  logic                  strob1,
	input  logic                  rst_n,
	input  logic [0:`PD_W-1]      w,         // W bus
	input  logic                  w_ir,      // IR load strobe
	input  logic                  si1,       // IR invalidate
	input  logic                  q,         // System flag
	input  logic [0:`PD_R0_W-1]   r0,        // R0 flags
	input  logic                  skip,
	output logic [0:`PD_W-1]      ir,
	output logic                  ir_valid,
	output pd_isa_pkg::op_class_t op_class,
	output logic                  c0,
	output logic                  b0,
	output logic                  xi,
	output logic                  nef,
	output pd_ctl_pkg::alu_fn_t   alu_fn,
	output logic                  aryt,
	output logic [0:`PD_W-1]      short_arg
);

	logic [0:`PD_FLD_W-1] a_field;
	logic [0:`PD_FLD_W-1] b_field;
	logic                 d_bit;

	pd_ir_dec i_ir_dec (
		.strob1   (strob1),
		.rst_n    (rst_n),
		.w        (w),
		.w_ir     (w_ir),
		.si1      (si1),
		.ir       (ir),
		.ir_valid (ir_valid),
		.op_class (op_class),
		.a_field  (a_field),
		.b_field  (b_field),
		.d_bit    (d_bit),
		.c0       (c0),
		.b0       (b0)
	);

	pd_legality #(
		.INOU_USER_ILLEGAL (INOU_USER_ILLEGAL)
	) i_legality (
		.ir_valid (ir_valid),
		.op_class (op_class),
		.a_field  (a_field),
		.b_field  (b_field),
		.q        (q),
		.r0       (r0),
		.skip     (skip),
		.xi       (xi),
		.nef      (nef)
	);

	pd_alu_ctl i_alu_ctl (
		.ir_valid  (ir_valid),
		.op_class  (op_class),
		.ir        (ir),
		.d_bit     (d_bit),
		.alu_fn    (alu_fn),
		.aryt      (aryt),
		.short_arg (short_arg)
	);

endmodule

/* testbench/pd_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps
`include "pd_consts.svh"

module pd_tb;

	localparam int    CLK_PERIOD = 100; // ns
	localparam int    DRIVE_DLY  = 10;  // Input skew after the rising edge
	localparam int    NCOL       = 13;  // Values per vector line
	localparam string VEC_FILE   = "testbench/pd_tests.txt";

	// Column positions in a vector line
	localparam int C_W    = 0;
	localparam int C_SI1  = 1;  // Strobe si1 once after the load
	localparam int C_Q    = 2;
	localparam int C_R0   = 3;
	localparam int C_SKIP = 4;
	localparam int C_OC   = 5;  // Expected values from here on
	localparam int C_C0   = 6;
	localparam int C_B0   = 7;
	localparam int C_XI   = 8;
	localparam int C_NEF  = 9;
	localparam int C_ALU  = 10;
	localparam int C_ARYT = 11;
	localparam int C_SA   = 12;

	logic                  strob1;
	logic                  rst_n;
	logic [0:`PD_W-1]      w;
	logic                  w_ir;
	logic                  si1;
	logic                  q;
	logic [0:`PD_R0_W-1]   r0;
	logic                  skip;
	logic [0:`PD_W-1]      ir;
	logic                  ir_valid;
	pd_isa_pkg::op_class_t op_class;
	logic                  c0;
	logic                  b0;
	logic                  xi;
	logic                  nef;
	pd_ctl_pkg::alu_fn_t   alu_fn;
	logic                  aryt;
	logic [0:`PD_W-1]      short_arg;

	logic [15:0] vec_q [$]; // Flat store of NCOL words per vector
	int          n_vec;
	int          errors;
	bit          loaded;    // Vectors read and watchdog armed

	pd_top i_dut (
		.strob1    (strob1),
		.rst_n     (rst_n),
		.w         (w),
		.w_ir      (w_ir),
		.si1       (si1),
		.q         (q),
		.r0        (r0),
		.skip      (skip),
		.ir        (ir),
		.ir_valid  (ir_valid),
		.op_class  (op_class),
		.c0        (c0),
		.b0        (b0),
		.xi        (xi),
		.nef       (nef),
		.alu_fn    (alu_fn),
		.aryt      (aryt),
		.short_arg (short_arg)
	);

	// 100 ns strob1
	initial begin
		strob1 = 1'b0;
		forever #(CLK_PERIOD/2) strob1 = ~strob1;
	end

	// Watchdog allows three cycles per vector plus reset margin
	initial begin
		wait (loaded);
		#((n_vec * 3 + 10) * CLK_PERIOD);
		$display("Timeout: run did not end within %0d cycles, %0d errors so far",
			n_vec * 3 + 10, errors);
		$display("Checks failed");
		$finish;
	end

	task automatic expect_equal(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp) else begin
			errors++;
			$display("error %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	function automatic logic [15:0] vec_field(input int k, input int c);
		return vec_q[k*NCOL + c];
	endfunction

	// Reads hex columns and skips lines starting with #
	task automatic read_vectors();
		int          fd;
		int          n;
		string       line;
		logic [15:0] col [NCOL];
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the vector file %s", VEC_FILE);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue; // Blank or note
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6],
				col[7], col[8], col[9], col[10], col[11], col[12]);
			if (n != NCOL) begin
				errors++;
				$display("Vector line has the wrong number of columns: %s", line);
			end else begin
				foreach (col[i])
					vec_q.push_back(col[i]);
			end
		end
		$fclose(fd);
	endtask

	// Everything quiet before the first load
	task automatic check_reset_state();
		expect_equal("ir", 16'h0, ir);
		expect_equal("ir_valid", 16'h0, 16'(ir_valid));
		expect_equal("xi", 16'h0, 16'(xi));
		expect_equal("nef", 16'h0, 16'(nef));
		expect_equal("aryt", 16'h0, 16'(aryt));
		expect_equal("c0", 16'h0, 16'(c0));
		expect_equal("b0", 16'h0, 16'(b0));
		expect_equal("alu_fn", 16'(pd_ctl_pkg::ALU_NONE), 16'(alu_fn));
		expect_equal("short_arg", 16'h0, short_arg);
	endtask

	task automatic check_outputs(input int k);
		logic [15:0] exp_ir;
		logic [15:0] si1_case;
		exp_ir   = vec_field(k, C_W);
		si1_case = vec_field(k, C_SI1);
		if (si1_case != 16'h0)
			exp_ir = exp_ir & 16'h3fff; // Opcode bits 0 and 1 knocked out
		expect_equal("ir", exp_ir, ir);
		expect_equal("ir_valid", 16'h1, 16'(ir_valid));
		expect_equal("op_class", vec_field(k, C_OC), 16'(op_class));
		expect_equal("c0", vec_field(k, C_C0), 16'(c0));
		expect_equal("b0", vec_field(k, C_B0), 16'(b0));
		expect_equal("xi", vec_field(k, C_XI), 16'(xi));
		expect_equal("nef", vec_field(k, C_NEF), 16'(nef));
		expect_equal("alu_fn", vec_field(k, C_ALU), 16'(alu_fn));
		expect_equal("aryt", vec_field(k, C_ARYT), 16'(aryt));
		expect_equal("short_arg", vec_field(k, C_SA), short_arg);
	endtask

	task automatic run_vector(input int k);
		logic [15:0] v [NCOL];
		logic [31:0] rnd;
		for (int i = 0; i < NCOL; i++)
			v[i] = vec_field(k, i);
		@(posedge strob1);
		#DRIVE_DLY;
		w    = v[C_W];
		w_ir = 1'b1;          // One-cycle load strobe
		q    = v[C_Q][0];
		r0   = v[C_R0][8:0];  // Z in the MSB
		skip = v[C_SKIP][0];
		@(posedge strob1);
		#DRIVE_DLY;
		rnd  = $urandom;
		w    = rnd[15:0];     // Padding word without a strobe
		w_ir = 1'b0;
		if (v[C_SI1][0]) begin
			si1 = 1'b1;
			@(posedge strob1);
			#DRIVE_DLY;
			si1 = 1'b0;
		end
		#DRIVE_DLY;           // Combinational outputs settled
		check_outputs(k);
	endtask

	initial begin
		errors = 0;
		n_vec  = 0;
		loaded = 1'b0;
		void'($urandom(32'h4f89_088f));
		rst_n  = 1'b0;
		w      = '0;
		w_ir   = 1'b0;
		si1    = 1'b0;
		q      = 1'b0;
		r0     = '0;
		skip   = 1'b1;  // nef must stay low until a load
		read_vectors();
		n_vec  = vec_q.size() / NCOL;
		if (n_vec == 0) begin
			errors++;
			$display("No test vectors were read from %s", VEC_FILE);
		end
		loaded = 1'b1;
		repeat (2) @(posedge strob1); // Reset for two cycles
		#DRIVE_DLY;
		rst_n = 1'b1;
		#DRIVE_DLY;
		check_reset_state();
		for (int k = 0; k < n_vec; k++)
			run_vector(k);
		$display("Ran %0d vectors, %0d errors", n_vec, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* testbench/pd_tests.txt */
# w si1 q r0 skip | expected op_class c0 b0 xi nef alu_fn aryt short_arg, all hex
# r0 holds Z in bit 8 down to X in bit 0; si1=1 strobes si1 once after the load
4053 0 0 000 0 1 1 1 0 0 1 1 0000
4400 0 0 000 0 1 0 0 0 0 2 1 0000
4805 0 0 000 0 1 1 0 0 0 3 0 0000
4c38 0 0 000 0 1 0 1 0 0 4 0 0000
53c0 0 0 000 0 1 0 0 0 0 5 0 0000
5409 0 0 000 0 1 1 1 0 0 6 0 0000
5800 0 0 000 0 1 0 0 0 0 6 0 0000
5c07 0 0 000 0 1 1 0 0 0 6 0 0000
bc1c 0 0 000 0 1 1 1 0 0 6 0 0000
4000 0 0 000 1 1 0 0 0 1 1 1 0000
c08a 0 0 000 0 2 1 1 0 0 1 1 000a
de3f 0 0 000 0 2 1 1 0 0 2 1 ffc1
c200 0 0 000 0 2 0 0 0 0 2 1 0000
c001 0 0 000 0 2 1 0 0 0 1 1 0001
e449 0 0 000 0 4 1 1 0 0 0 0 0000
e808 0 0 000 0 5 0 1 0 0 0 0 0000
e810 0 0 000 0 5 0 1 1 0 0 0 0000
ec00 0 0 000 0 6 0 0 0 0 0 0 0000
ec00 0 1 000 0 6 0 0 1 0 0 0 0000
ed40 0 0 000 0 6 0 0 1 0 0 0 0000
ed80 0 0 000 0 6 0 0 1 0 0 0 0000
edc0 0 0 000 0 6 0 0 1 0 0 0 0000
ed00 0 0 000 0 6 0 0 0 0 0 0 0000
ec00 0 0 000 1 6 0 0 0 1 0 0 0000
f000 0 0 000 0 7 0 0 0 0 0 0 0000
f000 0 1 000 0 7 0 0 1 0 0 0 0000
f400 0 1 000 0 7 0 0 1 0 0 0 0000
f400 0 0 000 1 7 0 0 0 1 0 0 0000
0000 0 0 000 0 0 0 0 1 0 0 0 0000
3c03 0 0 000 0 0 1 0 1 0 0 0 0000
2000 0 0 000 1 0 0 0 1 0 0 0 0000
f800 0 0 000 0 0 0 0 1 0 0 0 0000
fc00 0 0 000 1 0 0 0 1 0 0 0 0000
e000 0 0 000 0 3 0 0 0 0 6 0 0000
e000 0 0 000 1 3 0 0 0 1 6 0 0000
e040 0 0 000 0 3 0 0 0 1 6 0 0000
e040 0 0 100 0 3 0 0 0 0 6 0 0000
e080 0 0 080 0 3 0 0 0 0 6 0 0000
e080 0 0 17f 0 3 0 0 0 1 6 0 0000
e0c0 0 0 1bf 0 3 0 0 0 1 6 0 0000
e100 0 0 020 0 3 0 0 0 0 6 0 0000
e140 0 0 1ef 0 3 0 0 0 1 6 0 0000
e180 0 0 008 0 3 0 0 0 0 6 0 0000
e1c0 0 0 1fb 0 3 0 0 0 1 6 0 0000
e1c0 0 0 004 0 3 0 0 0 0 6 0 0000
ec27 0 0 000 0 6 1 1 0 0 0 0 0000
ec27 1 0 000 0 0 1 1 1 0 0 0 0000
c08a 1 0 000 0 0 1 1 1 0 0 0 0000

/* list.f */
+incdir+hw
hw/pd_isa_pkg.sv
hw/pd_ctl_pkg.sv
hw/pd_ir_dec.sv
hw/pd_legality.sv
hw/pd_alu_ctl.sv
hw/pd_top.sv
testbench/pd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Verilator build and run of pd_tb, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module pd_tb \
	-o pd_sim \
	&& ./obj_dir/pd_sim | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }
grep -qx "All checks passed" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
